// File: hb_dec.f
+incdir+include
verilog/hb_dec_pkg.sv
verilog/round_sd.sv
verilog/small_hb_dec.sv
verilog/hb_dec_iq.sv
dv/hb_dec_clk_gen.sv
dv/hb_dec_asserts.sv
dv/hb_dec_tb.sv

// File: Makefile
# Verilator lint and simulation for the complex halfband decimator

TOP = hb_dec_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f hb_dec.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f hb_dec.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation finished: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/hb_dec_tb.sv
// Directed testbench for the complex halfband decimator.
// Runs bypass, rate and latency, DC gain, impulse, clipping and run control
// tests, prints one line per test and then the counts and the verdict.
// Expected values come from the tap values and the timing of the block.

`timescale 1ns/1ps

`include "hb_dec_config.svh"

module hb_dec_tb;

   localparam int CLK_PERIOD = 4;

   // Cycle budget of each test; the watchdog allows their sum plus a margin
   localparam int LEN_BYPASS = 80;
   localparam int LEN_RATE   = 160;
   localparam int LEN_DC     = 120;
   localparam int LEN_IMP    = 130;
   localparam int LEN_CLIP   = 140;
   localparam int LEN_RUN    = 130;
   localparam int WATCHDOG_CYCLES = LEN_BYPASS + LEN_RATE + LEN_DC + LEN_IMP
                                  + LEN_CLIP + LEN_RUN + 100;

   // Taps on the 2^17 scale; the centre tap reaches the output at unit gain
   localparam longint TAP_A   = `HB_COEFF_A;
   localparam longint TAP_B   = `HB_COEFF_B;
   localparam longint SCALE   = 131072;
   localparam longint MAX_OUT = (1 << (`HB_WIDTH - 1)) - 1;
   localparam longint MIN_OUT = -(1 << (`HB_WIDTH - 1));

   logic                   clk;
   logic                   rst;
   logic                   bypass;
   logic                   run;
   logic                   stb_in;
   logic                   stb_out;
   hb_dec_pkg::iq_sample_t data_in;
   hb_dec_pkg::iq_sample_t data_out;

   integer seed = 11913;
   int     errors = 0;
   int     tests = 0;
   int     cyc = 0;
   int     low_outs = 0;
   logic   run_prev = 1'b0;
   logic   bypass_prev = 1'b0;

   // Strobe log, filled at the falling edge where all outputs are settled
   int                  in_cyc[$];
   int                  out_cyc[$];
   hb_dec_pkg::sample_t in_i[$];
   hb_dec_pkg::sample_t in_q[$];
   hb_dec_pkg::sample_t out_i[$];
   hb_dec_pkg::sample_t out_q[$];

   hb_dec_clk_gen clk_gen0 (
      .clk (clk),
      .rst (rst)
   );

   hb_dec_iq dut0 (
      .clk      (clk),
      .rst      (rst),
      .bypass   (bypass),
      .run      (run),
      .stb_in   (stb_in),
      .data_in  (data_in),
      .stb_out  (stb_out),
      .data_out (data_out)
   );

   bind hb_dec_iq hb_dec_asserts asserts0 (
      .clk     (clk),
      .rst     (rst),
      .bypass  (bypass),
      .run     (run),
      .stb_in  (stb_in),
      .stb_out (stb_out)
   );

   always @(posedge clk)
      cyc <= cyc + 1;

   // The output register samples run one cycle before the strobe shows,
   // so the previous falling-edge value is the one that gated it
   always @(negedge clk)
   begin
      if (stb_in)
      begin
         in_cyc.push_back(cyc);
         in_i.push_back(data_in.i);
         in_q.push_back(data_in.q);
      end
      if (stb_out)
      begin
         out_cyc.push_back(cyc);
         out_i.push_back(data_out.i);
         out_q.push_back(data_out.q);
         if (!run_prev && !bypass_prev)
            low_outs++;
      end
      run_prev = run;
      bypass_prev = bypass;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   task automatic check(input string name, input longint expected, input longint actual,
                        input longint tol);
      longint diff;
      diff = expected - actual;
      if (diff > tol || diff < -tol)
      begin
         $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
         errors++;
      end
   endtask

   function automatic longint div_round(input longint num, input longint den);
      if (num >= 0)
         return (num + den / 2) / den;
      return -((-num + den / 2) / den);
   endfunction

   function automatic longint saturate(input longint v);
      if (v > MAX_OUT)
         return MAX_OUT;
      if (v < MIN_OUT)
         return MIN_OUT;
      return v;
   endfunction

   // Seven-tap response over the newest sample x0 back to x6
   function automatic longint ref_output(input longint x0, input longint x2,
                                         input longint x3, input longint x4,
                                         input longint x6);
      longint num;
      num = 2 * TAP_A * (x0 + x6) + 2 * TAP_B * (x2 + x4) + 2 * SCALE * x3;
      return saturate(div_round(num, 2 * SCALE));
   endfunction

   // One strobe, then a quiet cycle
   task automatic send(input longint i_val, input longint q_val);
      @(posedge clk);
      stb_in <= 1'b1;
      data_in.i <= hb_dec_pkg::sample_t'(i_val);
      data_in.q <= hb_dec_pkg::sample_t'(q_val);
      @(posedge clk);
      stb_in <= 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n)
         @(posedge clk);
   endtask

   task automatic clear_log();
      in_cyc.delete();
      out_cyc.delete();
      in_i.delete();
      in_q.delete();
      out_i.delete();
      out_q.delete();
   endtask

   // Dropping run clears the decimation phase, so the next strobe starts a pair
   task automatic restart_run();
      @(posedge clk);
      run <= 1'b0;
      idle(2);
      run <= 1'b1;
   endtask

   task automatic wait_outputs(input string name, input int count, output bit ok);
      int waited;
      waited = 0;
      while (out_cyc.size() < count && waited < 40)
      begin
         @(posedge clk);
         waited++;
      end
      ok = (out_cyc.size() >= count);
      if (!ok)
      begin
         $display("Test %s: only %0d of %0d output strobes arrived", name,
                  out_cyc.size(), count);
         errors++;
      end
   endtask

   // Output m is computed when input 2m+1 completes its pair
   task automatic compare_stream(input string name, input int first, input int last,
                                 input longint tol);
      int n;
      for (int m = first; m <= last; m++)
      begin
         n = 2 * m + 1;
         check(name, ref_output(in_i[n], in_i[n-2], in_i[n-3], in_i[n-4], in_i[n-6]),
               out_i[m], tol);
         check(name, ref_output(in_q[n], in_q[n-2], in_q[n-3], in_q[n-4], in_q[n-6]),
               out_q[m], tol);
      end
   endtask

   task automatic finish_test(input string name, input int errs_at_start);
      tests++;
      if (errors == errs_at_start)
         $display("Test %s: ok", name);
      else
         $display("Test %s: %0d errors", name, errors - errs_at_start);
   endtask

   task automatic test_bypass();
      int e0;
      e0 = errors;
      @(posedge clk);
      bypass <= 1'b1;
      run <= 1'b1;
      clear_log();
      for (int k = 0; k < 20; k++)
         send($random(seed), $random(seed));
      idle(4);
      check("bypass", 20, out_cyc.size(), 0);
      for (int k = 0; k < 20 && k < out_cyc.size(); k++)
      begin
         check("bypass", in_cyc[k] + 1, out_cyc[k], 0);
         check("bypass", in_i[k], out_i[k], 0);
         check("bypass", in_q[k], out_q[k], 0);
      end
      run <= 1'b0;
      bypass <= 1'b0;
      idle(4);
      finish_test("bypass", e0);
   endtask

   // Random gaps between strobes must not move the 8-cycle latency
   task automatic test_rate();
      int e0;
      bit ok;
      e0 = errors;
      restart_run();
      clear_log();
      for (int k = 0; k < 16; k++)
      begin
         send($random(seed), $random(seed));
         idle($unsigned($random(seed)) % 3);
      end
      wait_outputs("rate", 8, ok);
      idle(12);
      check("rate", 8, out_cyc.size(), 0);
      if (ok)
         for (int m = 0; m < 8; m++)
            check("rate", in_cyc[2*m+1] + 8, out_cyc[m], 0);
      finish_test("rate", e0);
   endtask

   task automatic test_dc();
      int     e0;
      bit     ok;
      longint expected;
      e0 = errors;
      expected = div_round(40000 * (SCALE + 2 * TAP_A + 2 * TAP_B), SCALE);
      restart_run();
      clear_log();
      for (int k = 0; k < 24; k++)
         send(40000, 40000);
      wait_outputs("dc", 12, ok);
      idle(4);
      // From output 3 on the delay line holds only the constant
      if (ok)
         for (int m = 3; m < 12; m++)
         begin
            check("dc", expected, out_i[m], 2);
            check("dc", expected, out_q[m], 2);
         end
      finish_test("dc", e0);
   endtask

   // One impulse lands on the odd taps and one on the even taps
   task automatic test_impulse();
      int e0;
      bit ok;
      e0 = errors;
      restart_run();
      clear_log();
      for (int k = 0; k < 28; k++)
      begin
         if (k == 10 || k == 19)
            send(65536, -65536);
         else
            send(0, 0);
      end
      wait_outputs("impulse", 14, ok);
      idle(4);
      if (ok)
         compare_stream("impulse", 3, 13, 1);
      finish_test("impulse", e0);
   endtask

   task automatic test_clip();
      int     e0;
      bit     ok;
      longint hi;
      longint lo;
      e0 = errors;
      hi = saturate(div_round(MAX_OUT * (SCALE + 2 * TAP_A + 2 * TAP_B), SCALE));
      lo = saturate(div_round(MIN_OUT * (SCALE + 2 * TAP_A + 2 * TAP_B), SCALE));
      restart_run();
      clear_log();
      for (int k = 0; k < 32; k++)
      begin
         if (k < 16)
            send(MAX_OUT, MIN_OUT);
         else
            send(MIN_OUT, MAX_OUT);
      end
      wait_outputs("clip", 16, ok);
      idle(4);
      // Only outputs whose whole window lies in one half are compared
      if (ok)
      begin
         for (int m = 3; m <= 7; m++)
         begin
            check("clip", hi, out_i[m], 0);
            check("clip", lo, out_q[m], 0);
         end
         for (int m = 11; m <= 15; m++)
         begin
            check("clip", lo, out_i[m], 0);
            check("clip", hi, out_q[m], 0);
         end
      end
      finish_test("clip", e0);
   endtask

   task automatic test_run();
      int e0;
      bit ok;
      e0 = errors;
      restart_run();
      clear_log();
      low_outs = 0;
      for (int k = 0; k < 4; k++)
         send($random(seed), $random(seed));
      run <= 1'b0;
      for (int k = 0; k < 4; k++)
         send($random(seed), $random(seed));
      idle(12);
      check("run", 0, low_outs, 0);
      run <= 1'b1;
      clear_log();
      for (int k = 0; k < 4; k++)
         send($random(seed), $random(seed));
      wait_outputs("run", 2, ok);
      idle(12);
      check("run", 2, out_cyc.size(), 0);
      if (ok)
         check("run", in_cyc[1] + 8, out_cyc[0], 0);
      finish_test("run", e0);
   endtask

   initial
   begin
      bypass  = 1'b0;
      run     = 1'b0;
      stb_in  = 1'b0;
      data_in = '0;
      @(posedge clk);
      while (rst)
         @(posedge clk);
      test_bypass();
      test_rate();
      test_dc();
      test_impulse();
      test_clip();
      test_run();
      $display("Tests run: %0d, errors: %0d", tests, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: dv/hb_dec_asserts.sv
// Concurrent checks on strobe spacing and output timing of the decimator.
// Bound to hb_dec_iq from the testbench and reports through $error only.

`timescale 1ns/1ps

module hb_dec_asserts (
   input logic clk,
   input logic rst,
   input logic bypass,
   input logic run,
   input logic stb_in,
   input logic stb_out
);

   // Filter path selected and running, as the output register sees it
   logic filt;

   assign filt = run && !bypass;

   // Each output needs the multiplier twice, so input strobes need a gap
   a_stb_in_gap: assert property (@(posedge clk) disable iff (rst)
      !(stb_in && $past(stb_in)))
      else $error("stb_in high in two consecutive cycles");

   // Bypass is a single register stage
   a_bypass_delay: assert property (@(posedge clk) disable iff (rst)
      ($past(bypass) && !$past(rst)) |-> (stb_out == $past(stb_in)))
      else $error("bypass stb_out is not stb_in delayed by one cycle");

   // Decimated strobes come at most once in any three cycles
   a_dec_spacing: assert property (@(posedge clk) disable iff (rst)
      (stb_out && $past(filt) && $past(filt, 2) && $past(filt, 3))
      |-> !($past(stb_out) || $past(stb_out, 2)))
      else $error("filter stb_out pulses closer than three cycles");

endmodule

// File: dv/hb_dec_clk_gen.sv
// Clock and reset source for the decimator testbench.
// The clock has a 4 ns period; reset stays high over the first three rising edges.

`timescale 1ns/1ps

module hb_dec_clk_gen (
   output logic clk,
   output logic rst
);

   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   // Release on a clock edge so the DUT sees a clean synchronous reset
   initial
   begin
      rst = 1'b1;
      repeat (3)
         @(posedge clk);
      rst <= 1'b0;
   end

endmodule

// File: verilog/hb_dec_iq.sv
// Complex halfband decimator, two identical lanes for I and Q.
// Both lanes see the same strobe, run and bypass, so they run in
// lockstep and the I lane strobe stands for the pair.

`timescale 1ns/1ps

module hb_dec_iq (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   bypass,
   input  logic                   run,
   input  logic                   stb_in,
   input  hb_dec_pkg::iq_sample_t data_in,
   output logic                   stb_out,
   output hb_dec_pkg::iq_sample_t data_out
);

   // Lane results before they are packed back into the struct
   hb_dec_pkg::sample_t out_i;
   hb_dec_pkg::sample_t out_q;

   small_hb_dec lane_i (
      .clk      (clk),
      .rst      (rst),
      .bypass   (bypass),
      .run      (run),
      .stb_in   (stb_in),
      .data_in  (data_in.i),
      .stb_out  (stb_out),
      .data_out (out_i)
   );

   // Q strobe is identical to the I strobe and is not needed
   small_hb_dec lane_q (
      .clk      (clk),
      .rst      (rst),
      .bypass   (bypass),
      .run      (run),
      .stb_in   (stb_in),
      .data_in  (data_in.q),
      .stb_out  (),
      .data_out (out_q)
   );

   assign data_out = '{i: out_i, q: out_q};

endmodule

// File: verilog/small_hb_dec.sv
// One lane of the short halfband decimator, taps A, 0, B, 1/2, B, 0, A.
// Every second input strobe starts a computation that folds the
// symmetric taps and runs them through one shared 18x18 multiplier
// over two cycles. The output strobe follows the completing input
// strobe by 8 cycles. With bypass high the input is registered once
// and sent straight out. Input strobes must be at least 2 cycles apart.

`timescale 1ns/1ps

`include "hb_dec_config.svh"

module small_hb_dec (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 bypass,
   input  logic                 run,
   input  logic                 stb_in,
   input  hb_dec_pkg::sample_t  data_in,
   output logic                 stb_out,
   output hb_dec_pkg::sample_t  data_out
);

   // Taps on the 2^17 scale
   localparam hb_dec_pkg::coeff_t COEFF_A = `HB_COEFF_A;
   localparam hb_dec_pkg::coeff_t COEFF_B = `HB_COEFF_B;

   // Zero bits below the centre term so it lines up with the products
   localparam int CTR_SHIFT = `HB_ACC_WIDTH - `HB_INT_WIDTH - 2;

   // Rounded input and its strobe
   hb_dec_pkg::int_sample_t data_rnd;
   logic                    stb_rnd;

   // The same, registered once more
   hb_dec_pkg::int_sample_t data_rnd_d1;
   logic                    stb_rnd_d1;

   // Decimation phase and the computation sequence flags
   logic phase;
   logic go;
   logic go_d1;
   logic go_d2;
   logic go_d3;
   logic go_d4;

   // Delay line, d1 newest
   hb_dec_pkg::int_sample_t d1, d2, d3, d4, d5, d6;

   // Folded pairs and the centre term, all one bit wider than a sample
   logic signed [`HB_INT_WIDTH:0] sum_a;
   logic signed [`HB_INT_WIDTH:0] sum_b;
   logic signed [`HB_INT_WIDTH:0] middle;

   // Multiplier operands, product and accumulator
   logic signed [`HB_INT_WIDTH:0] mult_sum;
   hb_dec_pkg::coeff_t            mult_coeff;
   hb_dec_pkg::acc_t              prod;
   hb_dec_pkg::acc_t              accum;

   // Rounded accumulator with one guard bit, and its clipped form
   logic [`HB_WIDTH:0]   accum_rnd;
   hb_dec_pkg::sample_t  accum_clip;
   logic                 stb_round;

   // Input rounding 18 to 17 bits
   round_sd #(
      .WIDTH_IN  (`HB_WIDTH),
      .WIDTH_OUT (`HB_INT_WIDTH)
   ) round_in (
      .clk        (clk),
      .rst        (rst),
      .in         (data_in),
      .strobe_in  (stb_in),
      .out        (data_rnd),
      .strobe_out (stb_rnd)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
         stb_rnd_d1 <= 1'b0;
      else
         stb_rnd_d1 <= stb_rnd;
   end

   always_ff @(posedge clk)
   begin
      data_rnd_d1 <= data_rnd;
   end

   // Phase toggles per sample; the second sample of a pair launches go
   always_ff @(posedge clk)
   begin
      if (rst || !run)
         phase <= 1'b0;
      else if (stb_rnd_d1)
         phase <= ~phase;
   end

   assign go = stb_rnd_d1 & phase;

   // go_d1 and go_d2 drive the multiplier, go_d2 and go_d3 the accumulator,
   // go_d4 hands the result to the output rounding
   always_ff @(posedge clk)
   begin
      if (rst || !run)
      begin
         go_d1 <= 1'b0;
         go_d2 <= 1'b0;
         go_d3 <= 1'b0;
         go_d4 <= 1'b0;
      end
      else
      begin
         go_d1 <= go;
         go_d2 <= go_d1;
         go_d3 <= go_d2;
         go_d4 <= go_d3;
      end
   end

   // Shift one sample per strobe
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         d1 <= '0;
         d2 <= '0;
         d3 <= '0;
         d4 <= '0;
         d5 <= '0;
         d6 <= '0;
      end
      else if (stb_rnd_d1)
      begin
         d1 <= data_rnd_d1;
         d2 <= d1;
         d3 <= d2;
         d4 <= d3;
         d5 <= d4;
         d6 <= d5;
      end
   end

   // The newest sample and d6 share tap A, d2 and d4 share tap B,
   // and d3 sits on the centre tap
   always_ff @(posedge clk)
   begin
      if (go)
      begin
         sum_a  <= data_rnd_d1 + d6;
         sum_b  <= d2 + d4;
         middle <= {d3, 1'b0};
      end
   end

   // Outer pair first, inner pair on the next cycle
   assign mult_sum   = go_d2 ? sum_b : sum_a;
   assign mult_coeff = go_d2 ? COEFF_B : COEFF_A;

   // Registered 18x18 product
   always_ff @(posedge clk)
   begin
      if (go_d1 || go_d2)
         prod <= mult_coeff * mult_sum;
   end

   // Products are doubled and the centre term lands at unit gain,
   // which sets the DC gain to (2^17 + 2A + 2B) / 2^17
   always_ff @(posedge clk)
   begin
      if (go_d2)
         accum <= {middle[`HB_INT_WIDTH], middle, {CTR_SHIFT{1'b0}}} + (prod <<< 1);
      else if (go_d3)
         accum <= accum + (prod <<< 1);
   end

   // Output rounding 36 to 19 bits
   round_sd #(
      .WIDTH_IN  (`HB_ACC_WIDTH),
      .WIDTH_OUT (`HB_WIDTH + 1)
   ) round_acc (
      .clk        (clk),
      .rst        (rst),
      .in         (accum),
      .strobe_in  (go_d4),
      .out        (accum_rnd),
      .strobe_out (stb_round)
   );

   // Saturate when the guard bit disagrees with the sign
   assign accum_clip = (accum_rnd[`HB_WIDTH] != accum_rnd[`HB_WIDTH-1])
                     ? {accum_rnd[`HB_WIDTH], {(`HB_WIDTH-1){~accum_rnd[`HB_WIDTH]}}}
                     : accum_rnd[`HB_WIDTH-1:0];

   // Output register, filter result or bypassed input
   always_ff @(posedge clk)
   begin
      if (rst)
         stb_out <= 1'b0;
      else
         stb_out <= bypass ? stb_in : (stb_round & run);
   end

   always_ff @(posedge clk)
   begin
      data_out <= bypass ? data_in : accum_clip;
   end

endmodule

// File: verilog/round_sd.sv
// Error-feedback rounding from WIDTH_IN down to WIDTH_OUT bits.
// The bits dropped on one strobe are added back in on the next,
// so the rounding error is pushed to high frequency and the DC
// value carries no bias. Output and strobe come one cycle after
// strobe_in. A positive overflow from the added error saturates.

`timescale 1ns/1ps

module round_sd #(
   parameter int WIDTH_IN  = 18,
   parameter int WIDTH_OUT = 17
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [WIDTH_IN-1:0]  in,
   input  logic                 strobe_in,
   output logic [WIDTH_OUT-1:0] out,
   output logic                 strobe_out
);

   // Number of bits removed per sample
   localparam int ERR_W = WIDTH_IN - WIDTH_OUT;

   // Leftover fraction from the previous strobe, always non-negative
   logic [ERR_W-1:0] err;

   // Input plus leftover, one bit wider so the add cannot wrap
   logic signed [WIDTH_IN:0] sum;

   // Upper part of the sum, one guard bit above the output width
   logic signed [WIDTH_OUT:0] quot;

   // Guard bit and sign disagree, result out of range
   logic ovf;

   assign sum  = $signed({in[WIDTH_IN-1], in}) + $signed({1'b0, err});
   assign quot = sum[WIDTH_IN:ERR_W];
   assign ovf  = quot[WIDTH_OUT] != quot[WIDTH_OUT-1];

   // Control side: leftover error and the strobe
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         err        <= '0;
         strobe_out <= 1'b0;
      end
      else
      begin
         strobe_out <= strobe_in;
         if (strobe_in)
            err <= sum[ERR_W-1:0];
      end
   end

   // Rounded value, held between strobes
   always_ff @(posedge clk)
   begin
      if (strobe_in)
         out <= ovf ? {quot[WIDTH_OUT], {(WIDTH_OUT-1){~quot[WIDTH_OUT]}}}
                    : quot[WIDTH_OUT-1:0];
   end

endmodule

// File: verilog/hb_dec_pkg.sv
// Shared types for the halfband decimator.
// Modules refer to these through hb_dec_pkg:: scoped names.

`include "hb_dec_config.svh"

package hb_dec_pkg;

   // Signed sample as seen on the ports
   typedef logic signed [`HB_WIDTH-1:0] sample_t;

   // Sample after the input rounding stage
   typedef logic signed [`HB_INT_WIDTH-1:0] int_sample_t;

   // Multiplier product and accumulator
   typedef logic signed [`HB_ACC_WIDTH-1:0] acc_t;

   // One filter tap, sized for the 18-bit multiplier input
   typedef logic signed [17:0] coeff_t;

   // Complex sample, with I in the upper half
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_sample_t;

endpackage

// File: include/hb_dec_config.svh
// Build-time constants for the halfband decimator.
// Included by the package and by any RTL that needs the raw values.
// The taps are on a 2^17 scale and describe A, 0, B, 1/2, B, 0, A.

`ifndef HB_DEC_CONFIG_SVH
`define HB_DEC_CONFIG_SVH

// Sample width at the block ports
`define HB_WIDTH 18

// Width after input rounding, one bit short so folded sums fit the 18x18 multiplier
`define HB_INT_WIDTH 17

// Full product and accumulator width
`define HB_ACC_WIDTH 36

// Outer and inner taps
`define HB_COEFF_A (-10690)
`define HB_COEFF_B 75809

`endif
